//--- filelist.f
rtl/copper_pkg.sv
rtl/video_timing.sv
rtl/copper_prog_ram.sv
rtl/copper_sequencer.sv
rtl/xr_wb_master.sv
rtl/copper_top.sv
tests/tb_clock.sv
tests/copper_tb.sv

//--- rtl/copper_pkg.sv
//////////////////////////////////////////////////////////////////////
// Copper package
// Frame geometry, instruction encoding, register bus regions and the
// sequencer state codes shared by the copper blocks
//////////////////////////////////////////////////////////////////////
`default_nettype none

package copper_pkg;

    // Frame geometry, reduced for simulation
    localparam int H_TOTAL = 64;
    localparam int V_TOTAL = 16;
    localparam int POS_W   = 11;

    // Program memory
    localparam int PC_W       = 10;
    localparam int PROG_DEPTH = 1024;

    // Instruction word
    localparam int INSN_W = 32;

    // Opcodes in bits 31:28
    localparam logic [3:0] OP_WAIT  = 4'b0000;
    localparam logic [3:0] OP_SKIP  = 4'b0010;
    localparam logic [3:0] OP_JMP   = 4'b0100;
    localparam logic [3:0] OP_MOVER = 4'b1001;
    localparam logic [3:0] OP_MOVEF = 4'b1010;
    localparam logic [3:0] OP_MOVEP = 4'b1011;
    localparam logic [3:0] OP_MOVEC = 4'b1100;

    // Bit positions within the WAIT/SKIP flags field
    localparam int FLAG_IGNORE_V = 0;
    localparam int FLAG_IGNORE_H = 1;

    // External register bus
    localparam int XR_ADDR_W = 16;
    localparam int XR_DATA_W = 16;

    localparam logic [XR_ADDR_W-1:0] XR_REG_BASE   = 16'h0000;
    localparam logic [XR_ADDR_W-1:0] XR_TILE_MEM   = 16'h4000;
    localparam logic [XR_ADDR_W-1:0] XR_COLOR_MEM  = 16'h8000;
    localparam logic [XR_ADDR_W-1:0] XR_COPPER_MEM = 16'hC000;

    // Control register, enable on top, initial PC in the low bits
    localparam int CTRL_EN_BIT = 15;

    // Sequencer states
    localparam int              ST_W         = 3;
    localparam logic [ST_W-1:0] ST_INIT      = 3'd0;
    localparam logic [ST_W-1:0] ST_FETCH     = 3'd1;
    localparam logic [ST_W-1:0] ST_LATCH     = 3'd2;
    localparam logic [ST_W-1:0] ST_PRECOMP   = 3'd3;
    localparam logic [ST_W-1:0] ST_EXEC      = 3'd4;
    localparam logic [ST_W-1:0] ST_MOVE_WAIT = 3'd5;

    // WAIT, SKIP and JMP view of an instruction
    typedef struct packed {
        logic [3:0]       opcode;
        logic             pad_y;
        logic [POS_W-1:0] ypos;   // JMP target lives in ypos[10:1]
        logic             pad_x;
        logic [POS_W-1:0] xpos;
        logic [3:0]       flags;
    } copper_pos_t;

    // MOVEx view of an instruction
    typedef struct packed {
        logic [3:0]           opcode;
        logic [11:0]          addr;
        logic [XR_DATA_W-1:0] data;
    } copper_move_t;

    typedef union packed {
        copper_pos_t  pos;
        copper_move_t move;
    } copper_insn_t;

endpackage

`default_nettype wire

//--- rtl/copper_prog_ram.sv
//////////////////////////////////////////////////////////////////////
// Copper program RAM
// Host write port and a one-cycle registered read port for fetch
//////////////////////////////////////////////////////////////////////
`default_nettype none

module copper_prog_ram (
    input  wire logic                           clk,
    input  wire logic                           wr_en_i,
    input  wire logic [copper_pkg::PC_W-1:0]    wr_addr_i,
    input  wire logic [copper_pkg::INSN_W-1:0]  wr_data_i,
    input  wire logic [copper_pkg::PC_W-1:0]    rd_addr_i,
    output logic [copper_pkg::INSN_W-1:0]       rd_data_o
);

    import copper_pkg::*;

    logic [INSN_W-1:0] mem [PROG_DEPTH];

    // Host writes program words
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Sequencer read, data valid the cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    // A host write must land on a defined word
    a_wr_addr_known: assert property (
        @(posedge clk) wr_en_i |-> !$isunknown(wr_addr_i)
    ) else $error("program RAM write with unknown address");

endmodule

`default_nettype wire

//--- rtl/copper_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Copper sequencer
// Control register, program counter and the fetch / precompute /
// execute FSM, issues move requests to the bus master
//////////////////////////////////////////////////////////////////////
`default_nettype none

module copper_sequencer (
    input  wire logic                               clk,
    input  wire logic                               copp_reset,
    input  wire logic                               ctrl_wr_i,
    input  wire logic [copper_pkg::XR_DATA_W-1:0]   ctrl_data_i,
    input  wire logic [copper_pkg::POS_W-1:0]       h_count_i,
    input  wire logic [copper_pkg::POS_W-1:0]       v_count_i,
    input  wire logic                               frame_restart_i,
    output logic [copper_pkg::PC_W-1:0]             rd_addr_o,
    input  wire logic [copper_pkg::INSN_W-1:0]      rd_data_i,
    output logic                                    move_req_o,
    output copper_pkg::copper_insn_t                move_insn_o,
    input  wire logic                               move_done_i
);

    import copper_pkg::*;

    // Control register
    logic            copper_en;
    logic [PC_W-1:0] init_pc;

    logic [PC_W-1:0] pc;
    logic [ST_W-1:0] state;
    copper_insn_t    insn;

    // Registered in PRECOMP for use in EXEC
    logic            v_reached;
    logic            h_reached;
    logic [PC_W-1:0] pc_skip;

    // Decoded from the latched instruction
    logic            ignore_v;
    logic            ignore_h;
    logic            pos_hit;
    logic            wait_done;
    logic            is_move;
    logic [PC_W-1:0] pc_jmp;

    // Fetch always reads at the current PC
    assign rd_addr_o   = pc;
    assign move_insn_o = insn;

    always_comb begin
        ignore_v  = insn.pos.flags[FLAG_IGNORE_V];
        ignore_h  = insn.pos.flags[FLAG_IGNORE_H];
        pc_jmp    = insn.pos.ypos[POS_W-1:1];
        // An ignored coordinate counts as reached
        pos_hit   = (ignore_v || v_reached) && (ignore_h || h_reached);
        // Both ignored means hold until frame restart
        wait_done = pos_hit && !(ignore_v && ignore_h);
        case (insn.pos.opcode)
            OP_MOVER, OP_MOVEF, OP_MOVEP, OP_MOVEC: is_move = 1'b1;
            default:                                is_move = 1'b0;
        endcase
    end

    // One request per move, only on the EXEC cycle
    assign move_req_o = (state == ST_EXEC) && is_move;

    // Instruction latch and precompute
    always_ff @(posedge clk) begin
        if (state == ST_LATCH) begin
            insn <= rd_data_i;
        end
        if (state == ST_PRECOMP) begin
            v_reached <= (v_count_i >= insn.pos.ypos);
            h_reached <= (h_count_i >= insn.pos.xpos);
            pc_skip   <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en <= 1'b0;
            init_pc   <= '0;
            pc        <= '0;
            state     <= ST_INIT;
        end else begin
            if (ctrl_wr_i) begin
                copper_en <= ctrl_data_i[CTRL_EN_BIT];
                init_pc   <= ctrl_data_i[PC_W-1:0];
            end

            // Frame restart wins over everything else
            if (frame_restart_i) begin
                state <= ST_INIT;
                pc    <= init_pc;
            end else begin
                case (state)
                    ST_INIT: begin
                        if (copper_en) begin
                            state <= ST_FETCH;
                        end
                    end
                    // RAM samples the PC here, so step it now
                    ST_FETCH: begin
                        if (copper_en) begin
                            pc    <= pc + 1'b1;
                            state <= ST_LATCH;
                        end else begin
                            state <= ST_INIT;
                        end
                    end
                    ST_LATCH: begin
                        state <= ST_PRECOMP;
                    end
                    ST_PRECOMP: begin
                        state <= ST_EXEC;
                    end
                    ST_EXEC: begin
                        case (insn.pos.opcode)
                            OP_WAIT: begin
                                // Not there yet, compare again
                                state <= wait_done ? ST_FETCH : ST_PRECOMP;
                            end
                            OP_SKIP: begin
                                if (pos_hit) begin
                                    pc <= pc_skip;
                                end
                                state <= ST_FETCH;
                            end
                            OP_JMP: begin
                                pc    <= pc_jmp;
                                state <= ST_FETCH;
                            end
                            OP_MOVER, OP_MOVEF, OP_MOVEP, OP_MOVEC: begin
                                state <= ST_MOVE_WAIT;
                            end
                            // Illegal opcode, just move on
                            default: begin
                                state <= ST_FETCH;
                            end
                        endcase
                    end
                    ST_MOVE_WAIT: begin
                        if (move_done_i) begin
                            state <= ST_FETCH;
                        end
                    end
                    default: begin
                        state <= ST_INIT;
                    end
                endcase
            end
        end
    end

    // A done only answers the move that is being waited on
    a_done_in_move_wait: assert property (
        @(posedge clk) disable iff (copp_reset)
        move_done_i |-> (state == ST_MOVE_WAIT)
    ) else $error("move done without an outstanding move");

endmodule

`default_nettype wire

//--- rtl/copper_top.sv
//////////////////////////////////////////////////////////////////////
// Copper top level
// Video timing, program RAM, sequencer and Wishbone master
//////////////////////////////////////////////////////////////////////
`default_nettype none

module copper_top (
    input  wire logic                               clk,
    input  wire logic                               copp_reset,
    // Host access
    input  wire logic                               ctrl_wr_i,
    input  wire logic [copper_pkg::XR_DATA_W-1:0]   ctrl_data_i,
    input  wire logic                               prog_wr_i,
    input  wire logic [copper_pkg::PC_W-1:0]        prog_addr_i,
    input  wire logic [copper_pkg::INSN_W-1:0]      prog_data_i,
    // Wishbone write master
    output logic                                    wb_cyc_o,
    output logic                                    wb_stb_o,
    output logic                                    wb_we_o,
    output logic [copper_pkg::XR_ADDR_W-1:0]        wb_adr_o,
    output logic [copper_pkg::XR_DATA_W-1:0]        wb_dat_o,
    input  wire logic                               wb_ack_i,
    // Beam position
    output logic [copper_pkg::POS_W-1:0]            h_count_o,
    output logic [copper_pkg::POS_W-1:0]            v_count_o
);

    import copper_pkg::*;

    logic              frame_restart;
    logic [PC_W-1:0]   rd_addr;
    logic [INSN_W-1:0] rd_data;
    logic              move_req;
    copper_insn_t      move_insn;
    logic              move_done;

    video_timing video_timing_inst (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .h_count_o       (h_count_o),
        .v_count_o       (v_count_o),
        .frame_restart_o (frame_restart)
    );

    copper_prog_ram copper_prog_ram_inst (
        .clk       (clk),
        .wr_en_i   (prog_wr_i),
        .wr_addr_i (prog_addr_i),
        .wr_data_i (prog_data_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    copper_sequencer copper_sequencer_inst (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .ctrl_wr_i       (ctrl_wr_i),
        .ctrl_data_i     (ctrl_data_i),
        .h_count_i       (h_count_o),
        .v_count_i       (v_count_o),
        .frame_restart_i (frame_restart),
        .rd_addr_o       (rd_addr),
        .rd_data_i       (rd_data),
        .move_req_o      (move_req),
        .move_insn_o     (move_insn),
        .move_done_i     (move_done)
    );

    xr_wb_master xr_wb_master_inst (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .frame_restart_i (frame_restart),
        .move_req_i      (move_req),
        .move_insn_i     (move_insn),
        .move_done_o     (move_done),
        .wb_cyc_o        (wb_cyc_o),
        .wb_stb_o        (wb_stb_o),
        .wb_we_o         (wb_we_o),
        .wb_adr_o        (wb_adr_o),
        .wb_dat_o        (wb_dat_o),
        .wb_ack_i        (wb_ack_i)
    );

endmodule

`default_nettype wire

//--- rtl/video_timing.sv
//////////////////////////////////////////////////////////////////////
// Video timing
// Free-running beam counters and the frame restart pulse on the
// last pixel of each frame
//////////////////////////////////////////////////////////////////////
`default_nettype none

module video_timing (
    input  wire logic                       clk,
    input  wire logic                       copp_reset,
    output logic [copper_pkg::POS_W-1:0]    h_count_o,
    output logic [copper_pkg::POS_W-1:0]    v_count_o,
    output logic                            frame_restart_o
);

    import copper_pkg::*;

    logic h_last;
    logic v_last;

    // Last pixel of a line and last line of a frame
    assign h_last = (h_count_o == POS_W'(H_TOTAL - 1));
    assign v_last = (v_count_o == POS_W'(V_TOTAL - 1));

    // One cycle at the very end of the frame
    assign frame_restart_o = h_last && v_last;

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            h_count_o <= '0;
            v_count_o <= '0;
        end else if (h_last) begin
            h_count_o <= '0;
            // Line wraps, step or wrap the vertical count
            if (v_last) begin
                v_count_o <= '0;
            end else begin
                v_count_o <= v_count_o + 1'b1;
            end
        end else begin
            h_count_o <= h_count_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/xr_wb_master.sv
//////////////////////////////////////////////////////////////////////
// XR bus Wishbone master
// Maps a move instruction to a region address and runs one classic
// Wishbone write, reporting completion when ack arrives
//////////////////////////////////////////////////////////////////////
`default_nettype none

module xr_wb_master (
    input  wire logic                           clk,
    input  wire logic                           copp_reset,
    input  wire logic                           frame_restart_i,
    input  wire logic                           move_req_i,
    input  wire copper_pkg::copper_insn_t       move_insn_i,
    output logic                                move_done_o,
    output logic                                wb_cyc_o,
    output logic                                wb_stb_o,
    output logic                                wb_we_o,
    output logic [copper_pkg::XR_ADDR_W-1:0]    wb_adr_o,
    output logic [copper_pkg::XR_DATA_W-1:0]    wb_dat_o,
    input  wire logic                           wb_ack_i
);

    import copper_pkg::*;

    logic [XR_ADDR_W-1:0] move_adr;

    // Region base OR'd with the field width each opcode allows
    always_comb begin
        case (move_insn_i.move.opcode)
            OP_MOVEF: move_adr = XR_TILE_MEM   | {4'h0, move_insn_i.move.addr};
            OP_MOVEP: move_adr = XR_COLOR_MEM  | {8'h00, move_insn_i.move.addr[7:0]};
            OP_MOVEC: move_adr = XR_COPPER_MEM | {5'h00, move_insn_i.move.addr[10:0]};
            default:  move_adr = XR_REG_BASE   | {8'h00, move_insn_i.move.addr[7:0]};
        endcase
    end

    // Write-only master
    assign wb_we_o = wb_cyc_o;

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            wb_cyc_o    <= 1'b0;
            wb_stb_o    <= 1'b0;
            move_done_o <= 1'b0;
        end else begin
            move_done_o <= 1'b0;
            if (frame_restart_i) begin
                // Abort, the sequencer restarts anyway
                wb_cyc_o <= 1'b0;
                wb_stb_o <= 1'b0;
            end else if (wb_cyc_o) begin
                if (wb_ack_i) begin
                    wb_cyc_o    <= 1'b0;
                    wb_stb_o    <= 1'b0;
                    move_done_o <= 1'b1;
                end
            end else if (move_req_i) begin
                wb_cyc_o <= 1'b1;
                wb_stb_o <= 1'b1;
            end
        end
    end

    // Address and data captured when a cycle opens
    always_ff @(posedge clk) begin
        if (!wb_cyc_o && move_req_i) begin
            wb_adr_o <= move_adr;
            wb_dat_o <= move_insn_i.move.data;
        end
    end

    // Held steady until ack, unless the cycle was aborted
    a_stable_until_ack: assert property (
        @(posedge clk) disable iff (copp_reset)
        (wb_stb_o && !wb_ack_i) |=> (!wb_stb_o || ($stable(wb_adr_o) && $stable(wb_dat_o)))
    ) else $error("wishbone address or data changed before ack");

    a_stb_needs_cyc: assert property (
        @(posedge clk) disable iff (copp_reset) wb_stb_o |-> wb_cyc_o
    ) else $error("wishbone stb without cyc");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the copper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module copper_tb \
    -o copper_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/copper_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

//--- tests/copper_tb.sv
//////////////////////////////////////////////////////////////////////
// Copper testbench
// Table of copper programs with their expected Wishbone writes,
// a Wishbone target with random ack delay and a per-test report
//////////////////////////////////////////////////////////////////////
`default_nettype none

module copper_tb;

    import copper_pkg::*;

    localparam int NT      = 6;
    localparam int TIMEOUT = 3 * H_TOTAL * V_TOTAL;

    logic                 clk;
    logic                 copp_reset;
    logic                 ctrl_wr_i;
    logic [XR_DATA_W-1:0] ctrl_data_i;
    logic                 prog_wr_i;
    logic [PC_W-1:0]      prog_addr_i;
    logic [INSN_W-1:0]    prog_data_i;
    logic                 wb_cyc_o;
    logic                 wb_stb_o;
    logic                 wb_we_o;
    logic [XR_ADDR_W-1:0] wb_adr_o;
    logic [XR_DATA_W-1:0] wb_dat_o;
    logic                 wb_ack_i;
    logic [POS_W-1:0]     h_count_o;
    logic [POS_W-1:0]     v_count_o;

    // Test table
    string       name_tab    [NT];
    logic [31:0] prog_tab    [NT][8];
    int          nwords_tab  [NT];
    logic [9:0]  base_tab    [NT];
    logic [15:0] ctrl_tab    [NT];
    bit          keep_tab    [NT];
    int          frames_tab  [NT];
    int          nexp_tab    [NT];
    logic [15:0] exp_adr_tab [NT][4];
    logic [15:0] exp_dat_tab [NT][4];
    int          min_h_tab   [NT][4];
    int          min_v_tab   [NT][4];

    // Writes seen by the target, with the beam position where stb rose
    logic [15:0] got_adr_q [$];
    logic [15:0] got_dat_q [$];
    int          got_h_q   [$];
    int          got_v_q   [$];

    int seed = 32'h5eca;
    int errors = 0;
    int checks = 0;
    int failed_tests = 0;
    int cyc_cycles = 0;
    int ack_wait = 0;
    int start_h = 0;
    int start_v = 0;
    bit in_cycle = 1'b0;

    tb_clock tb_clock_inst (
        .clk_o (clk)
    );

    copper_top copper_top_inst (
        .clk         (clk),
        .copp_reset  (copp_reset),
        .ctrl_wr_i   (ctrl_wr_i),
        .ctrl_data_i (ctrl_data_i),
        .prog_wr_i   (prog_wr_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_i    (wb_ack_i),
        .h_count_o   (h_count_o),
        .v_count_o   (v_count_o)
    );

    // Instruction encoders, field layout as in the instruction format
    function automatic logic [31:0] enc_move(logic [3:0] op, logic [11:0] adr,
                                             logic [15:0] dat);
        return {op, adr, dat};
    endfunction

    function automatic logic [31:0] enc_pos(logic [3:0] op, logic [10:0] y,
                                            logic [10:0] x, logic [3:0] fl);
        return {op, 1'b0, y, 1'b0, x, fl};
    endfunction

    // Word address sits in bits 26:17
    function automatic logic [31:0] enc_jmp(logic [9:0] tgt);
        return {OP_JMP, 1'b0, tgt, 1'b0, 12'h000, 4'h0};
    endfunction

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic timeout_fail(string what);
        $display("timeout: %s did not happen within 3 frames", what);
        $display("Something failed");
        $finish;
    endtask

    task automatic add_word(int t, logic [31:0] w);
        prog_tab[t][nwords_tab[t]] = w;
        nwords_tab[t]++;
    endtask

    task automatic add_write(int t, logic [15:0] adr, logic [15:0] dat, int mh, int mv);
        exp_adr_tab[t][nexp_tab[t]] = adr;
        exp_dat_tab[t][nexp_tab[t]] = dat;
        min_h_tab[t][nexp_tab[t]]   = mh;
        min_v_tab[t][nexp_tab[t]]   = mv;
        nexp_tab[t]++;
    endtask

    task automatic new_test(int t, string name, logic [9:0] base, logic [15:0] ctrl,
                            bit keep, int frames);
        name_tab[t]   = name;
        base_tab[t]   = base;
        ctrl_tab[t]   = ctrl;
        keep_tab[t]   = keep;
        frames_tab[t] = frames;
        nwords_tab[t] = 0;
        nexp_tab[t]   = 0;
    endtask

    task automatic build_table();
        // Copper disabled, no bus traffic at all
        new_test(0, "disabled", 10'h000, 16'h0000, 1'b0, 1);
        add_word(0, enc_move(OP_MOVER, 12'h001, 16'hDEAD));
        add_word(0, enc_pos(OP_WAIT, 11'd0, 11'd0, 4'b0011));

        // One write per region, illegal opcode in between, field masking
        new_test(1, "moves", 10'h010, 16'h8010, 1'b0, 1);
        add_word(1, enc_move(OP_MOVER, 12'h012, 16'h1111));
        add_word(1, enc_move(OP_MOVEF, 12'hABC, 16'h2222));
        add_word(1, 32'hF000_0000);
        add_word(1, enc_move(OP_MOVEP, 12'h155, 16'h3333));
        add_word(1, enc_move(OP_MOVEC, 12'h7FF, 16'h4444));
        add_word(1, enc_pos(OP_WAIT, 11'd0, 11'd0, 4'b0011));
        add_write(1, 16'h0012, 16'h1111, 0, 0);
        add_write(1, 16'h4ABC, 16'h2222, 0, 0);
        add_write(1, 16'h8055, 16'h3333, 0, 0);
        add_write(1, 16'hC7FF, 16'h4444, 0, 0);

        // WAIT on both, on Y only and on X only
        // The ignored coordinate is out of reach of the beam
        new_test(2, "wait", 10'h020, 16'h8020, 1'b0, 1);
        add_word(2, enc_pos(OP_WAIT, 11'd5, 11'd20, 4'b0000));
        add_word(2, enc_move(OP_MOVER, 12'h001, 16'hAAAA));
        add_word(2, enc_pos(OP_WAIT, 11'd9, 11'h7FF, 4'b0010));
        add_word(2, enc_move(OP_MOVER, 12'h002, 16'hBBBB));
        add_word(2, enc_pos(OP_WAIT, 11'h7FF, 11'd40, 4'b0001));
        add_word(2, enc_move(OP_MOVER, 12'h003, 16'hCCCC));
        add_word(2, enc_pos(OP_WAIT, 11'd0, 11'd0, 4'b0011));
        add_write(2, 16'h0001, 16'hAAAA, 20, 5);
        add_write(2, 16'h0002, 16'hBBBB, 0, 9);
        add_write(2, 16'h0003, 16'hCCCC, 40, 0);

        // SKIP past, SKIP future, JMP over a move
        new_test(3, "skip and jmp", 10'h030, 16'h8030, 1'b0, 1);
        add_word(3, enc_pos(OP_SKIP, 11'd0, 11'd0, 4'b0000));
        add_word(3, enc_move(OP_MOVER, 12'h010, 16'h0001));
        add_word(3, enc_pos(OP_SKIP, 11'd12, 11'd0, 4'b0000));
        add_word(3, enc_move(OP_MOVER, 12'h011, 16'h0002));
        add_word(3, enc_jmp(10'h036));
        add_word(3, enc_move(OP_MOVER, 12'h012, 16'h0003));
        add_word(3, enc_move(OP_MOVER, 12'h013, 16'h0004));
        add_word(3, enc_pos(OP_WAIT, 11'd0, 11'd0, 4'b0011));
        add_write(3, 16'h0011, 16'h0002, 0, 0);
        add_write(3, 16'h0013, 16'h0004, 0, 0);

        // Same writes again after the frame restart
        new_test(4, "two frames", 10'h040, 16'h8040, 1'b0, 2);
        add_word(4, enc_move(OP_MOVEP, 12'h001, 16'h5A5A));
        add_word(4, enc_move(OP_MOVEC, 12'h002, 16'hA5A5));
        add_word(4, enc_pos(OP_WAIT, 11'd0, 11'd0, 4'b0011));
        add_write(4, 16'h8001, 16'h5A5A, 0, 0);
        add_write(4, 16'hC002, 16'hA5A5, 0, 0);
        add_write(4, 16'h8001, 16'h5A5A, 0, 0);
        add_write(4, 16'hC002, 16'hA5A5, 0, 0);

        // Initial PC changed while running
        new_test(5, "new initial pc", 10'h050, 16'h8050, 1'b1, 1);
        add_word(5, enc_move(OP_MOVEF, 12'h123, 16'h7777));
        add_word(5, enc_pos(OP_WAIT, 11'd0, 11'd0, 4'b0011));
        add_write(5, 16'h4123, 16'h7777, 0, 0);
    endtask

    // Wishbone target, acks after 0 to 3 cycles
    always @(posedge clk) begin
        if (copp_reset) begin
            wb_ack_i <= 1'b0;
            in_cycle = 1'b0;
        end else begin
            if (wb_cyc_o || wb_stb_o) begin
                cyc_cycles++;
            end
            if (wb_stb_o && wb_ack_i) begin
                check_value("wb_we_o", 32'(wb_we_o), 32'd1);
                got_adr_q.push_back(wb_adr_o);
                got_dat_q.push_back(wb_dat_o);
                got_h_q.push_back(start_h);
                got_v_q.push_back(start_v);
                in_cycle = 1'b0;
                wb_ack_i <= 1'b0;
            end else if (wb_stb_o) begin
                // First cycle of stb, note where the beam is
                if (!in_cycle) begin
                    in_cycle = 1'b1;
                    ack_wait = $random(seed) & 3;
                    start_h  = int'(h_count_o);
                    start_v  = int'(v_count_o);
                end
                if (ack_wait == 0) begin
                    wb_ack_i <= 1'b1;
                end else begin
                    ack_wait--;
                end
            end else begin
                // Idle or an aborted cycle
                in_cycle = 1'b0;
                wb_ack_i <= 1'b0;
            end
        end
    end

    task automatic write_ctrl(logic [15:0] value);
        @(posedge clk);
        ctrl_wr_i   <= 1'b1;
        ctrl_data_i <= value;
        @(posedge clk);
        ctrl_wr_i   <= 1'b0;
    endtask

    task automatic load_program(int t);
        for (int i = 0; i < nwords_tab[t]; i++) begin
            @(posedge clk);
            prog_wr_i   <= 1'b1;
            prog_addr_i <= base_tab[t] + 10'(i);
            prog_data_i <= prog_tab[t][i];
        end
        @(posedge clk);
        prog_wr_i <= 1'b0;
    endtask

    // Beam leaves 0,0 and comes back, sampled on the falling edge
    task automatic wait_frame_start();
        int n;
        n = 0;
        while (h_count_o == '0 && v_count_o == '0) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                timeout_fail("beam leaving 0,0");
            end
        end
        n = 0;
        while (!(h_count_o == '0 && v_count_o == '0)) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                timeout_fail("frame restart");
            end
        end
    endtask

    task automatic run_test(int t);
        int err_before;
        int n;
        err_before = errors;
        if (!keep_tab[t]) begin
            // Stop first so the next restart lands on the new initial PC
            write_ctrl({6'b0, base_tab[t]});
        end
        load_program(t);
        if (!keep_tab[t]) begin
            wait_frame_start();
        end
        write_ctrl(ctrl_tab[t]);
        wait_frame_start();
        got_adr_q.delete();
        got_dat_q.delete();
        got_h_q.delete();
        got_v_q.delete();
        cyc_cycles = 0;
        for (int f = 0; f < frames_tab[t]; f++) begin
            wait_frame_start();
        end
        check_value("write count", 32'(got_adr_q.size()), 32'(nexp_tab[t]));
        if (!ctrl_tab[t][CTRL_EN_BIT]) begin
            check_value("wb_cyc_o and wb_stb_o cycles", 32'(cyc_cycles), 32'd0);
        end
        n = (got_adr_q.size() < nexp_tab[t]) ? got_adr_q.size() : nexp_tab[t];
        for (int i = 0; i < n; i++) begin
            check_value("wb_adr_o", 32'(got_adr_q[i]), 32'(exp_adr_tab[t][i]));
            check_value("wb_dat_o", 32'(got_dat_q[i]), 32'(exp_dat_tab[t][i]));
            check_value("stb h_count_o reached",
                        32'(got_h_q[i] >= min_h_tab[t][i]), 32'd1);
            check_value("stb v_count_o reached",
                        32'(got_v_q[i] >= min_v_tab[t][i]), 32'd1);
        end
        if (errors == err_before) begin
            $display("test %0d %s: pass", t, name_tab[t]);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAIL", t, name_tab[t]);
        end
    endtask

    initial begin
        copp_reset  = 1'b1;
        ctrl_wr_i   = 1'b0;
        ctrl_data_i = '0;
        prog_wr_i   = 1'b0;
        prog_addr_i = '0;
        prog_data_i = '0;
        wb_ack_i    = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        copp_reset <= 1'b0;
        for (int t = 0; t < NT; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NT, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock
// Free-running clock with a period of 100 time units
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_clock (
    output logic clk_o
);

    // Low first, rising edge at 50
    initial begin
        clk_o = 1'b0;
    end

    always #50 clk_o = ~clk_o;

endmodule

`default_nettype wire
